// ==== backup_ctrl.sv ====
/*
 * Control FSM of the backup store. Picks up load, save, mount and autosave
 * triggers, then steps sectors through SD requests and buffer moves.
 */

module backup_ctrl (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                bk_load,
	input  logic                bk_save,
	input  logic                bk_autosave,
	input  logic                osd_status,
	input  logic                img_mounted,
	input  logic                bk_ena,
	input  logic                bk_pending,
	input  backup_pkg::sector_t save_sz,
	input  logic                sd_ack,
	output logic                sd_rd,
	output logic                sd_wr,
	output backup_pkg::sector_t sd_lba,
	output logic                loading,
	output logic                move_start,
	input  logic                move_done,
	output logic                busy
);
	import backup_pkg::*;

	bk_state_e state;

	logic old_load, old_save, old_save_a;
	logic mount_d1, mount_d2; // Mount seen a cycle late behind the size update
	logic save_a;
	logic load_req, save_req, trigger;

	// ====================
	// Trigger detection
	// ====================

	assign save_a   = osd_status && bk_autosave;
	assign load_req = (bk_load && !old_load) || (mount_d1 && !mount_d2);
	assign save_req = (bk_save && !old_save) || (save_a && !old_save_a && bk_pending);
	assign trigger  = bk_ena && (load_req || save_req);

	assign busy = (state != st_idle);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_save_a <= 1'b0;
			mount_d1   <= 1'b0;
			mount_d2   <= 1'b0;
		end else begin
			old_load   <= bk_load;
			old_save   <= bk_save;
			old_save_a <= save_a;
			mount_d1   <= img_mounted;
			mount_d2   <= mount_d1;
		end
	end

	// ====================
	// Sector sequence
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= st_idle;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			loading    <= 1'b0;
			move_start <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					sd_lba  <= '0;
					loading <= 1'b0;
					if (trigger) begin
						loading <= load_req;     // Load wins over save
						if (load_req) begin
							sd_rd <= 1'b1;       // Load starts on SD
							state <= st_sd_request;
						end else begin
							state <= st_move_start; // Save starts on memory
						end
					end
				end
				st_sd_request: if (sd_ack) begin
					sd_rd <= 1'b0;           // Request accepted
					sd_wr <= 1'b0;
					state <= st_sd_finish;
				end
				st_sd_finish: if (!sd_ack) begin
					if (loading) begin
						state <= st_move_start;  // Copy the full buffer to memory
					end else if (sd_lba == save_sz) begin
						state <= st_idle;        // Last save sector written
					end else begin
						sd_lba <= sd_lba + 1'b1;
						state  <= st_move_start;
					end
				end
				st_move_start: begin
					move_start <= 1'b1;
					state      <= st_move_wait;
				end
				st_move_wait: if (move_done) begin
					move_start <= 1'b0;          // Mover clears its index
					if (!loading) begin
						sd_wr <= 1'b1;
						state <= st_sd_request;
					end else if (&sd_lba) begin
						state <= st_idle;        // Always reads the full 256
					end else begin
						sd_lba <= sd_lba + 1'b1;
						sd_rd  <= 1'b1;
						state  <= st_sd_request;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== backup_pkg.sv ====
/*
 * Save media, save size constants and controller states for the backup-RAM store.
 * The tracker, the controller and the top level import it.
 */

package backup_pkg;

	// ====================
	// Save media
	// ====================

	typedef enum logic [1:0] {
		media_eeprom, // Serial EEPROM up to 8 KB
		media_sram,   // Battery SRAM
		media_flash   // 64 KB flash or 128 KB with flash_1m
	} save_media_e;

	// Sector number and save size
	localparam int SECTOR_CNT_W = 8;
	typedef logic [SECTOR_CNT_W-1:0] sector_t;

	// Last sector index per media ORed into the save size
	localparam sector_t SZ_EEPROM   = 8'd15;
	localparam sector_t SZ_SRAM     = 8'd63;
	localparam sector_t SZ_FLASH    = 8'd127;
	localparam sector_t SZ_FLASH_1M = 8'd255;

	// ====================
	// Controller FSM
	// ====================

	typedef enum logic [2:0] {
		st_idle,       // Wait for a trigger
		st_sd_request, // sd_rd or sd_wr held until ack rises
		st_sd_finish,  // Wait for ack to fall
		st_move_start, // Kick the word mover
		st_move_wait   // Wait for the whole buffer to move
	} bk_state_e;

endpackage

// ==== backup_store_top.sv ====
/*
 * Top level of the backup-RAM store. Save memory sits on the mem_* port,
 * the SD host on the sd_* ports. busy falls when a load or save ends.
 */

module backup_store_top #(
	parameter int BUF_ADDR_W = 8 // 256 words per sector
) (
	input  logic                          clk_sys,
	input  logic                          reset,
	// Triggers
	input  logic                          bk_load,
	input  logic                          bk_save,
	input  logic                          bk_autosave,
	input  logic                          osd_status,
	// Image and game
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	input  logic [bus_pkg::IMG_SIZE_W-1:0] img_size,
	input  logic                          new_game,
	input  logic                          game_save_wr,
	input  backup_pkg::save_media_e       save_media,
	input  logic                          flash_1m,
	// Save memory
	output logic                          mem_req,
	output bus_pkg::mem_op_e              mem_op,
	output logic [backup_pkg::SECTOR_CNT_W+BUF_ADDR_W-1:0] mem_addr,
	output bus_pkg::word_t                mem_wdata,
	input  bus_pkg::word_t                mem_rdata,
	input  logic                          mem_ready,
	// SD host
	output backup_pkg::sector_t           sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	input  logic                          sd_ack,
	input  logic [BUF_ADDR_W-1:0]         sd_buff_addr,
	input  logic                          sd_buff_wr,
	input  bus_pkg::word_t                sd_buff_dout,
	output bus_pkg::word_t                sd_buff_din,
	// Status
	output logic                          busy,
	output logic                          bk_pending
);
	import backup_pkg::*;

	sector_t               save_sz;
	logic                  bk_ena;
	logic                  loading;
	logic                  move_start, move_done;
	logic [BUF_ADDR_W-1:0] word_idx;

	buf_port_if #(.BUF_ADDR_W(BUF_ADDR_W)) buf_bus ();

	assign mem_addr = {sd_lba, word_idx}; // Sector then word

	backup_ctrl ctrl_i (.*);

	save_size_tracker tracker_i (.*);

	word_mover #(.BUF_ADDR_W(BUF_ADDR_W)) mover_i (
		.clk_sys, .reset, .move_start, .loading, .move_done,
		.buf_port(buf_bus.mover),
		.mem_req, .mem_op, .mem_wdata, .mem_rdata, .mem_ready, .word_idx
	);

	sector_buffer #(.BUF_ADDR_W(BUF_ADDR_W)) buffer_i (
		.clk_sys,
		.port(buf_bus.buffer),
		.sd_buff_addr, .sd_buff_wr, .sd_buff_dout, .sd_buff_din
	);

endmodule

// ==== buf_port_if.sv ====
/*
 * Block-buffer port between the word mover and the sector buffer.
 * Read data returns one cycle after the address.
 */

interface buf_port_if #(
	parameter int BUF_ADDR_W = 8
);
	import bus_pkg::*;

	logic [BUF_ADDR_W-1:0] addr;  // Word index inside the sector
	logic                  we;    // Write strobe
	word_t                 wdata; // Word from memory on save
	word_t                 rdata; // Registered read

	// Mover side
	modport mover (output addr, output we, output wdata, input rdata);

	// RAM side
	modport buffer (input addr, input we, input wdata, output rdata);

endinterface

// ==== bus_pkg.sv ====
/*
 * Bus widths and the memory opcode shared by the datapath.
 * Imported by the buffer, the word mover and the size tracker.
 */

package bus_pkg;

	// ====================
	// Data words
	// ====================

	localparam int WORD_W = 16;      // Buffer and save memory word
	typedef logic [WORD_W-1:0] word_t;

	// Image size from the SD host, in bytes
	localparam int IMG_SIZE_W = 64;
	localparam int SECTOR_BYTES_LOG2 = 9; // 512-byte sectors

	// ====================
	// Memory opcode
	// ====================

	typedef enum logic {
		mem_read,  // Save: memory to buffer
		mem_write  // Load: buffer to memory
	} mem_op_e;

endpackage

// ==== compile.f ====
backup_pkg.sv
bus_pkg.sv
buf_port_if.sv
sector_buffer.sv
word_mover.sv
save_size_tracker.sv
backup_ctrl.sv
backup_store_top.sv
tb_backup_models.sv
tb_backup_store.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the backup store testbench with Verilator and runs it.
# The exit status is the simulator's own; a failing run ends in $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_backup_store -f compile.f -o tb_backup_store
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/tb_backup_store
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

echo "Simulation finished cleanly"
exit 0

// ==== save_size_tracker.sv ====
/*
 * Tracks the save length in sectors, the backup enable and unsaved writes.
 * Size comes from the game's save media or from a mounted image.
 */

module save_size_tracker (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          new_game,
	input  logic                          game_save_wr,
	input  backup_pkg::save_media_e       save_media,
	input  logic                          flash_1m,
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	input  logic [bus_pkg::IMG_SIZE_W-1:0] img_size,
	input  logic                          busy,
	output backup_pkg::sector_t           save_sz,
	output logic                          bk_ena,
	output logic                          bk_pending
);
	import backup_pkg::*;
	import bus_pkg::*;

	logic    use_img;     // Image locks out media updates
	logic    img_next;
	sector_t media_sz;    // Last sector for current media
	sector_t img_sectors; // Image size in sectors
	sector_t sz_next;

	assign img_sectors = img_size[SECTOR_BYTES_LOG2 +: SECTOR_CNT_W];

	always_comb begin
		case (save_media)
			media_eeprom: media_sz = SZ_EEPROM;
			media_sram:   media_sz = SZ_SRAM;
			media_flash:  media_sz = flash_1m ? SZ_FLASH_1M : SZ_FLASH;
			default:      media_sz = '0;
		endcase
	end

	// Next size where an image mount overrides everything
	always_comb begin
		sz_next  = save_sz;
		img_next = use_img;
		if (new_game) begin
			sz_next  = '0;
			img_next = 1'b0;
		end else if (game_save_wr && !use_img) begin
			sz_next = save_sz | media_sz;   // Grows only
		end
		if (img_mounted && img_size != '0 && !img_readonly) begin
			sz_next  = img_sectors - 1'b1;  // Last sector index
			img_next = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			save_sz    <= '0;
			use_img    <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			save_sz <= sz_next;
			use_img <= img_next;
			bk_ena  <= |sz_next;                // Same cycle as save_sz
			if (game_save_wr)
				bk_pending <= 1'b1;
			else if (busy)
				bk_pending <= 1'b0;             // Store under way
		end
	end

endmodule

// ==== sector_buffer.sv ====
/*
 * Dual-port block buffer holding one sector.
 * Port A faces the word mover, port B the SD host.
 */

module sector_buffer #(
	parameter int BUF_ADDR_W = 8
) (
	input  logic                  clk_sys,
	buf_port_if.buffer            port,
	input  logic [BUF_ADDR_W-1:0] sd_buff_addr,
	input  logic                  sd_buff_wr,
	input  bus_pkg::word_t        sd_buff_dout,
	output bus_pkg::word_t        sd_buff_din
);
	import bus_pkg::*;

	localparam int DEPTH = 2 ** BUF_ADDR_W;

	word_t ram [DEPTH]; // One sector of words

	// Writes from both sides with SD winning a clash
	always_ff @(posedge clk_sys) begin
		if (port.we)
			ram[port.addr] <= port.wdata;
		if (sd_buff_wr)
			ram[sd_buff_addr] <= sd_buff_dout;
	end

	// Registered reads on both ports
	always_ff @(posedge clk_sys) begin
		port.rdata  <= ram[port.addr];   // Mover side
		sd_buff_din <= ram[sd_buff_addr]; // SD side
	end

endmodule

// ==== tb_backup_models.sv ====
/*
 * Behavioral SD host and save memory for the backup store testbench.
 * Both answer the DUT with random delays and keep their contents in arrays.
 */

// ====================
// SD host with a 256-sector image
// ====================

module sd_host_model #(
	parameter int BUF_ADDR_W = 4
) (
	input  logic                  clk_sys,
	input  backup_pkg::sector_t   sd_lba,
	input  logic                  sd_rd,
	input  logic                  sd_wr,
	output logic                  sd_ack,
	output logic [BUF_ADDR_W-1:0] sd_buff_addr,
	output logic                  sd_buff_wr,
	output bus_pkg::word_t        sd_buff_dout,
	input  bus_pkg::word_t        sd_buff_din
);
	import backup_pkg::*;
	import bus_pkg::*;

	localparam int DEPTH = 2 ** BUF_ADDR_W;

	word_t   img [256 * DEPTH]; // Indexed by sector then word
	int      rd_count;          // Sectors read so far
	int      wr_count;          // Sectors written so far
	sector_t last_wr_lba;

	initial begin
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr   = 1'b0;
		sd_buff_dout = '0;
		rd_count     = 0;
		wr_count     = 0;
		last_wr_lba  = '0;
	end

	// One request at a time with ack held over the whole buffer transfer
	always begin : serve
		sector_t lba;
		logic    is_rd;
		int      delay;
		@(posedge clk_sys);
		if (sd_rd || sd_wr) begin
			lba   = sd_lba;
			is_rd = sd_rd;
			delay = int'($urandom_range(4, 0)); // SD back-pressure
			repeat (delay) @(posedge clk_sys);
			sd_ack <= 1'b1;
			if (is_rd) begin
				for (int i = 0; i < DEPTH; i++) begin
					sd_buff_addr <= BUF_ADDR_W'(i);
					sd_buff_wr   <= 1'b1;
					sd_buff_dout <= img[{lba, BUF_ADDR_W'(i)}];
					@(posedge clk_sys);
				end
				sd_buff_wr <= 1'b0;
				rd_count++;
			end else begin
				for (int i = 0; i < DEPTH; i++) begin
					sd_buff_addr <= BUF_ADDR_W'(i);
					repeat (2) @(posedge clk_sys); // Registered read in the buffer
					img[{lba, BUF_ADDR_W'(i)}] = sd_buff_din;
				end
				wr_count++;
				last_wr_lba = lba;
			end
			sd_ack <= 1'b0; // Sector done on the fall
		end
	end

endmodule

// ====================
// Save memory
// ====================

module save_mem_model #(
	parameter int ADDR_W = 12
) (
	input  logic              clk_sys,
	input  logic              mem_req,
	input  bus_pkg::mem_op_e  mem_op,
	input  logic [ADDR_W-1:0] mem_addr,
	input  bus_pkg::word_t    mem_wdata,
	output bus_pkg::word_t    mem_rdata,
	output logic              mem_ready
);
	import bus_pkg::*;

	word_t mem [2 ** ADDR_W];

	initial begin
		mem_rdata = '0;
		mem_ready = 1'b0;
	end

	always begin : serve
		logic [ADDR_W-1:0] addr;
		mem_op_e           op;
		word_t             data;
		int                delay;
		@(posedge clk_sys);
		if (mem_req) begin
			addr  = mem_addr;  // Latched with the request
			op    = mem_op;
			data  = mem_wdata;
			delay = int'($urandom_range(3, 0));
			repeat (delay) @(posedge clk_sys);
			if (op == mem_write)
				mem[addr] = data;
			else
				mem_rdata <= mem[addr];
			mem_ready <= 1'b1; // One-cycle ready
			@(posedge clk_sys);
			mem_ready <= 1'b0;
		end
	end

endmodule

// ==== tb_backup_store.sv ====
/*
 * Testbench for the backup-RAM store. Runs a table of saves and one mount,
 * then autosave, and checks SD traffic and memory contents against fill patterns.
 */

module tb_backup_store;
	import backup_pkg::*;
	import bus_pkg::*;

	localparam int BUF_ADDR_W = 4;
	localparam int DEPTH      = 2 ** BUF_ADDR_W;
	localparam int MEM_ADDR_W = SECTOR_CNT_W + BUF_ADDR_W;
	localparam int MEM_WORDS  = 2 ** MEM_ADDR_W;
	localparam int ROWS       = 5;
	localparam int TIMEOUT_CYCLES = ROWS * 256 * 16 * 40; // Rows x sectors x words x cycles

	typedef enum logic {op_save, op_mount} op_e;

	typedef struct packed {
		op_e         op;
		save_media_e media;
		logic        flash_1m;
		logic [8:0]  img_sectors; // Mount only
		logic [8:0]  exp_sectors; // Sectors written on save or read on load
	} row_t;

	localparam row_t ROW_TABLE [ROWS] = '{
		'{op_save,  media_eeprom, 1'b0, 9'd0,  9'd16},
		'{op_save,  media_sram,   1'b0, 9'd0,  9'd64},
		'{op_save,  media_flash,  1'b0, 9'd0,  9'd128},
		'{op_save,  media_flash,  1'b1, 9'd0,  9'd256},
		'{op_mount, media_eeprom, 1'b0, 9'd40, 9'd256} // Load always reads 256
	};

	logic clk_sys, reset;
	logic bk_load, bk_save, bk_autosave, osd_status;
	logic img_mounted, img_readonly, new_game, game_save_wr, flash_1m;
	logic [IMG_SIZE_W-1:0] img_size;
	save_media_e save_media;
	logic mem_req, mem_ready;
	mem_op_e mem_op;
	logic [MEM_ADDR_W-1:0] mem_addr;
	word_t mem_wdata, mem_rdata;
	sector_t sd_lba;
	logic sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [BUF_ADDR_W-1:0] sd_buff_addr;
	word_t sd_buff_dout, sd_buff_din;
	logic busy, bk_pending;
	int cycles = 0;

	backup_store_top #(.BUF_ADDR_W(BUF_ADDR_W)) dut_i (.*);
	sd_host_model #(.BUF_ADDR_W(BUF_ADDR_W)) sd_i (.*);
	save_mem_model #(.ADDR_W(MEM_ADDR_W)) mem_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ====================
	// Checks
	// ====================

	task automatic stop_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input word_t exp, input word_t got, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %h got %h", $time, what, exp, got);
			stop_run();
		end
	endtask

	task automatic check_sector(input sector_t exp, input sector_t got, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, what, exp, got);
			stop_run();
		end
	endtask

	task automatic check_flag(input logic exp, input logic got, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %b got %b", $time, what, exp, got);
			stop_run();
		end
	endtask

	task automatic check_count(input int exp, input int got, input string what);
		if (got != exp) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, what, exp, got);
			stop_run();
		end
	endtask

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with the controller stuck in %s",
				cycles, dut_i.ctrl_i.state.name());
			stop_run();
		end
	end

	// ====================
	// Helpers
	// ====================

	function automatic word_t fill_word(input int addr, input word_t key);
		return word_t'(addr * 40503) ^ key; // Odd multiplier keeps every address distinct
	endfunction

	task automatic tick(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic fill_memory(input word_t key);
		for (int a = 0; a < MEM_WORDS; a++)
			mem_i.mem[MEM_ADDR_W'(a)] = fill_word(a, key);
	endtask

	task automatic fill_image(input word_t key);
		for (int a = 0; a < MEM_WORDS; a++)
			sd_i.img[MEM_ADDR_W'(a)] = fill_word(a, key);
	endtask

	task automatic run_to_idle();
		while (!busy) @(posedge clk_sys);
		while (busy) @(posedge clk_sys); // Fall of busy ends the operation
	endtask

	task automatic expect_no_start(input string what);
		repeat (8) begin
			tick(1);
			check_flag(1'b0, busy, what);
		end
	endtask

	task automatic game_write();
		game_save_wr <= 1'b1;
		tick(1);
		game_save_wr <= 1'b0;
		tick(1);
		check_flag(1'b1, bk_pending, "bk_pending after game write");
	endtask

	task automatic check_saved(input int wr_before, input int sectors, input word_t key);
		check_count(wr_before + sectors, sd_i.wr_count, "SD write count");
		check_sector(sector_t'(sectors - 1), sd_i.last_wr_lba, "last written sector");
		check_flag(1'b0, bk_pending, "bk_pending after save");
		for (int a = 0; a < sectors * DEPTH; a++)
			check_word(fill_word(a, key), sd_i.img[MEM_ADDR_W'(a)], "SD image word");
	endtask

	// ====================
	// Stimulus
	// ====================

	initial begin : stimulus
		int    wr_before;
		int    rd_before;
		word_t key;
		row_t  row;
		void'($urandom(32'h59e9_b603));
		reset = 1'b1;
		{bk_load, bk_save, bk_autosave, osd_status} = '0;
		{img_mounted, img_readonly, new_game, game_save_wr, flash_1m} = '0;
		img_size   = '0;
		save_media = media_eeprom;
		fill_memory(16'h1111);
		fill_image(16'h2222);
		tick(5);
		reset <= 1'b0;
		tick(1);

		// Reset state
		check_flag(1'b0, busy, "busy");
		check_flag(1'b0, sd_rd, "sd_rd");
		check_flag(1'b0, sd_wr, "sd_wr");
		check_flag(1'b0, mem_req, "mem_req");
		check_flag(1'b0, bk_pending, "bk_pending");
		check_sector('0, sd_lba, "sd_lba");

		// Save with no game write since new_game
		new_game <= 1'b1;
		tick(1);
		new_game <= 1'b0;
		bk_save  <= 1'b1;
		tick(1);
		bk_save <= 1'b0;
		expect_no_start("busy after save without game write");

		for (int r = 0; r < ROWS; r++) begin
			row       = ROW_TABLE[r];
			key       = word_t'(16'h3000 + r);
			wr_before = sd_i.wr_count;
			rd_before = sd_i.rd_count;
			new_game   <= 1'b1;
			save_media <= row.media;
			flash_1m   <= row.flash_1m;
			tick(1);
			new_game <= 1'b0;
			if (row.op == op_save) begin
				fill_memory(key);
				game_write();
				bk_save <= 1'b1;
				tick(1);
				bk_save <= 1'b0;
				run_to_idle();
				check_count(rd_before, sd_i.rd_count, "SD read count on save");
				check_saved(wr_before, int'(row.exp_sectors), key);
			end else begin
				fill_image(key);
				img_size    <= 64'(row.img_sectors) << SECTOR_BYTES_LOG2;
				img_mounted <= 1'b1;
				tick(1);
				img_mounted <= 1'b0;
				run_to_idle();
				check_sector(sector_t'(row.img_sectors - 1), dut_i.save_sz, "save_sz");
				check_count(rd_before + int'(row.exp_sectors), sd_i.rd_count, "SD reads");
				check_count(wr_before, sd_i.wr_count, "SD write count on load");
				for (int a = 0; a < MEM_WORDS; a++)
					check_word(fill_word(a, key), mem_i.mem[MEM_ADDR_W'(a)], "memory word");
			end
		end

		// Autosave on an osd_status rise needs a pending write
		key       = 16'h7a7a;
		wr_before = sd_i.wr_count;
		new_game    <= 1'b1;
		save_media  <= media_eeprom;
		flash_1m    <= 1'b0;
		bk_autosave <= 1'b1;
		tick(1);
		new_game <= 1'b0;
		fill_memory(key);
		game_write();
		osd_status <= 1'b1;
		run_to_idle();
		check_saved(wr_before, 16, key);
		osd_status <= 1'b0;
		tick(2);
		osd_status <= 1'b1;
		expect_no_start("busy on autosave with nothing pending");
		osd_status <= 1'b0;

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== word_mover.sv ====
/*
 * Moves one buffer of words between the sector buffer and save memory.
 * Runs while move_start is high, one memory handshake per word.
 */

module word_mover #(
	parameter int BUF_ADDR_W = 8
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  move_start, // Level from the controller
	input  logic                  loading,    // 1 = buffer to memory
	output logic                  move_done,
	buf_port_if.mover             buf_port,
	output logic                  mem_req,
	output bus_pkg::mem_op_e      mem_op,
	output bus_pkg::word_t        mem_wdata,
	input  bus_pkg::word_t        mem_rdata,
	input  logic                  mem_ready,
	output logic [BUF_ADDR_W-1:0] word_idx
);
	import bus_pkg::*;

	typedef enum logic [1:0] {
		ph_read,  // Buffer read in flight
		ph_issue, // mem_req high
		ph_wait,  // Waiting for mem_ready
		ph_done   // Last word finished
	} phase_e;

	phase_e phase;
	logic   word_end;

	// Handshake may complete in the request cycle itself
	assign word_end = mem_ready && (phase == ph_issue || phase == ph_wait);

	assign buf_port.addr  = word_idx;
	assign buf_port.wdata = mem_rdata;                 // Save path
	assign buf_port.we    = !loading && word_end;      // Capture in the ready cycle

	assign mem_req   = (phase == ph_issue);            // One cycle per word
	assign mem_op    = loading ? mem_write : mem_read;
	assign mem_wdata = buf_port.rdata;                 // Stable while addr holds
	assign move_done = (phase == ph_done);

	always_ff @(posedge clk_sys) begin
		if (reset || !move_start) begin
			phase    <= ph_read;
			word_idx <= '0;
		end else begin
			case (phase)
				ph_read: phase <= ph_issue;
				ph_issue, ph_wait: begin
					if (word_end) begin
						if (&word_idx) begin
							phase <= ph_done;   // Whole buffer moved
						end else begin
							word_idx <= word_idx + 1'b1;
							phase    <= ph_read;
						end
					end else begin
						phase <= ph_wait;
					end
				end
				default: phase <= ph_done;      // Hold until move_start drops
			endcase
		end
	end

endmodule
